// File: Makefile
VERILATOR ?= verilator
TOP       := tb_efpga_xfer
FILELIST  := filelist.f
FLAGS     := --binary --timing --assert -Wno-fatal
OBJ_DIR   := obj_dir
PASS_MSG  := ALL TESTS PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: efpga_xfer_pkg.sv
`default_nettype none

package efpga_xfer_pkg;

   localparam int WORD_W      = 32;
   localparam int TCDM_ADDR_W = 20;   // byte address
   localparam int LINT_ADDR_W = 20;
   localparam int RAM_ADDR_W  = 12;
   localparam int BE_W        = 4;
   localparam int LEN_W       = 8;    // words per transfer
   localparam int FIFO_DEPTH  = 4;    // also the credits a start hands out
   localparam int CREDIT_W    = 3;
   localparam int WORD_STRIDE = 4;

   localparam logic [LINT_ADDR_W-1:0] REG_CFG    = 20'h00000;
   localparam logic [LINT_ADDR_W-1:0] REG_LEN    = 20'h00004;
   localparam logic [LINT_ADDR_W-1:0] REG_START  = 20'h00008;
   localparam logic [LINT_ADDR_W-1:0] REG_STATUS = 20'h0000c;
   localparam logic [LINT_ADDR_W-1:0] REG_ID     = 20'h00800;

   localparam logic [7:0] RAM_WINDOW = 8'h01;   // page in lint_addr[19:12]

   localparam logic [WORD_W-1:0] ID_WORD = 32'hca11ef3a;

   // lint slave states
   localparam logic [1:0] LINT_IDLE  = 2'd0;
   localparam logic [1:0] LINT_WRITE = 2'd1;
   localparam logic [1:0] LINT_READ  = 2'd2;
   localparam logic [1:0] LINT_RWAIT = 2'd3;

   typedef union packed {
      logic [WORD_W-1:0] raw;
      struct packed {
         logic [7:0]             rsvd;   // reads as zero
         logic [BE_W-1:0]        be_n;   // byte enables, inverted
         logic [TCDM_ADDR_W-1:0] addr;
      } f;
   } tcdm_cfg_u;

endpackage

`default_nettype wire

// File: efpga_xfer_top.sv
`timescale 1ns/100ps
`default_nettype none

module efpga_xfer_top import efpga_xfer_pkg::*; (
   input  wire                    CLK,
   input  wire                    rst_n,
   input  wire                    lint_req,
   input  wire                    lint_wen,
   input  wire [LINT_ADDR_W-1:0]  lint_addr,
   input  wire [WORD_W-1:0]       lint_wdata,
   output logic                   lint_gnt,
   output logic                   lint_valid,
   output logic [WORD_W-1:0]      lint_rdata,
   output logic                   tcdm_req,
   output logic [TCDM_ADDR_W-1:0] tcdm_addr,
   output logic [BE_W-1:0]        tcdm_be,
   input  wire                    tcdm_gnt,
   input  wire                    tcdm_valid,
   input  wire [WORD_W-1:0]       tcdm_rdata,
   output logic                   ram_we,
   output logic [RAM_ADDR_W-1:0]  ram_waddr,
   output logic [WORD_W-1:0]      ram_wdata,
   output logic [RAM_ADDR_W-1:0]  ram_raddr,
   input  wire [WORD_W-1:0]       ram_rdata
);

   logic                   start;
   logic [TCDM_ADDR_W-1:0] start_addr;
   logic [BE_W-1:0]        start_be;
   logic [LEN_W-1:0]       length;
   logic                   done;
   logic [LEN_W-1:0]       words_done;

   xfer_if xf ();

   lint_regs u_regs (
      .CLK        (CLK),
      .rst_n      (rst_n),
      .lint_req   (lint_req),
      .lint_wen   (lint_wen),
      .lint_addr  (lint_addr),
      .lint_wdata (lint_wdata),
      .lint_gnt   (lint_gnt),
      .lint_valid (lint_valid),
      .lint_rdata (lint_rdata),
      .ram_raddr  (ram_raddr),
      .ram_rdata  (ram_rdata),
      .start      (start),
      .start_addr (start_addr),
      .start_be   (start_be),
      .length     (length),
      .done       (done),
      .words_done (words_done)
   );

   tcdm_reader u_reader (
      .CLK        (CLK),
      .rst_n      (rst_n),
      .start      (start),
      .start_addr (start_addr),
      .start_be   (start_be),
      .length     (length),
      .tcdm_req   (tcdm_req),
      .tcdm_addr  (tcdm_addr),
      .tcdm_be    (tcdm_be),
      .tcdm_gnt   (tcdm_gnt),
      .tcdm_valid (tcdm_valid),
      .tcdm_rdata (tcdm_rdata),
      .x          (xf.reader)
   );

   word_fifo u_fifo (
      .CLK   (CLK),
      .rst_n (rst_n),
      .b     (xf.buffer)
   );

   ram_writer u_writer (
      .CLK        (CLK),
      .rst_n      (rst_n),
      .start      (start),
      .length     (length),
      .ram_we     (ram_we),
      .ram_waddr  (ram_waddr),
      .ram_wdata  (ram_wdata),
      .done       (done),
      .words_done (words_done),
      .w          (xf.writer)
   );

endmodule

`default_nettype wire

// File: filelist.f
efpga_xfer_pkg.sv
xfer_if.sv
lint_regs.sv
tcdm_reader.sv
word_fifo.sv
ram_writer.sv
efpga_xfer_top.sv
tb_clock.sv
tb_efpga_xfer.sv

// File: lint_regs.sv
`timescale 1ns/100ps
`default_nettype none

module lint_regs import efpga_xfer_pkg::*; (
   input  wire                    CLK,
   input  wire                    rst_n,
   input  wire                    lint_req,
   input  wire                    lint_wen,     // low for a write
   input  wire [LINT_ADDR_W-1:0]  lint_addr,
   input  wire [WORD_W-1:0]       lint_wdata,
   output logic                   lint_gnt,
   output logic                   lint_valid,
   output logic [WORD_W-1:0]      lint_rdata,
   output logic [RAM_ADDR_W-1:0]  ram_raddr,
   input  wire [WORD_W-1:0]       ram_rdata,
   output logic                   start,
   output logic [TCDM_ADDR_W-1:0] start_addr,
   output logic [BE_W-1:0]        start_be,
   output logic [LEN_W-1:0]       length,
   input  wire                    done,
   input  wire [LEN_W-1:0]        words_done
);

   logic [1:0]        state;
   tcdm_cfg_u         cfg;
   logic [LEN_W-1:0]  len_q;
   logic              busy;
   logic              done_seen;   // sticky until next start
   logic              ram_sel;
   logic [WORD_W-1:0] reg_rdata;

   assign ram_sel    = (lint_addr[LINT_ADDR_W-1:RAM_ADDR_W] == RAM_WINDOW);
   assign start_addr = cfg.f.addr;
   assign start_be   = ~cfg.f.be_n;
   assign length     = len_q;

   always_comb begin
      case (lint_addr)
         REG_CFG:    reg_rdata = cfg.raw;
         REG_LEN:    reg_rdata = {{(WORD_W-LEN_W){1'b0}}, len_q};
         REG_STATUS: reg_rdata = {{(WORD_W-16){1'b0}}, words_done, 6'b000000, done_seen, busy};
         REG_ID:     reg_rdata = ID_WORD;
         default:    reg_rdata = '0;
      endcase
   end

   always_ff @(posedge CLK or negedge rst_n) begin
      if (!rst_n) begin
         state      <= LINT_IDLE;
         lint_gnt   <= 1'b0;
         lint_valid <= 1'b0;
         lint_rdata <= '0;
         ram_raddr  <= '0;
         cfg.raw    <= '0;
         len_q      <= '0;
         start      <= 1'b0;
      end else begin
         lint_gnt   <= 1'b0;
         lint_valid <= 1'b0;
         start      <= 1'b0;
         case (state)
            LINT_IDLE: begin
               if (lint_req) begin
                  if (!lint_wen) begin
                     lint_gnt <= 1'b1;
                     state    <= LINT_WRITE;
                  end else begin
                     ram_raddr <= lint_addr[RAM_ADDR_W-1:0];   // ram answers next cycle
                     state     <= LINT_READ;
                  end
               end
            end
            LINT_WRITE: begin
               lint_valid <= 1'b1;
               state      <= LINT_IDLE;
               case (lint_addr)
                  REG_CFG: begin
                     cfg.raw    <= lint_wdata;
                     cfg.f.rsvd <= '0;
                  end
                  REG_LEN:   len_q <= lint_wdata[LEN_W-1:0];
                  REG_START: start <= ~busy;   // ignored mid-transfer
                  default: ;
               endcase
            end
            LINT_READ: begin
               lint_gnt <= 1'b1;
               state    <= LINT_RWAIT;
            end
            LINT_RWAIT: begin
               lint_valid <= 1'b1;
               lint_rdata <= ram_sel ? ram_rdata : reg_rdata;
               state      <= LINT_IDLE;
            end
            default: state <= LINT_IDLE;
         endcase
      end
   end

   always_ff @(posedge CLK or negedge rst_n) begin
      if (!rst_n) begin
         busy      <= 1'b0;
         done_seen <= 1'b0;
      end else if (start) begin
         busy      <= 1'b1;
         done_seen <= 1'b0;
      end else if (done) begin
         busy      <= 1'b0;
         done_seen <= 1'b1;
      end
   end

   // grant and response of one access always land in separate cycles
   a_gnt_valid_apart: assert property (@(posedge CLK) disable iff (!rst_n)
      !(lint_gnt && lint_valid))
      else $error("lint_gnt and lint_valid high together");

endmodule

`default_nettype wire

// File: ram_writer.sv
`timescale 1ns/100ps
`default_nettype none

module ram_writer import efpga_xfer_pkg::*; (
   input  wire                   CLK,
   input  wire                   rst_n,
   input  wire                   start,
   input  wire [LEN_W-1:0]       length,
   output logic                  ram_we,
   output logic [RAM_ADDR_W-1:0] ram_waddr,
   output logic [WORD_W-1:0]     ram_wdata,
   output logic                  done,
   output logic [LEN_W-1:0]      words_done,
   xfer_if.writer                w
);

   assign w.pop = w.avail;   // drain as soon as a word shows up

   always_ff @(posedge CLK or negedge rst_n) begin
      if (!rst_n) begin
         ram_we     <= 1'b0;
         ram_waddr  <= '0;
         done       <= 1'b0;
         words_done <= '0;
      end else begin
         ram_we <= w.avail;
         done   <= (start && (length == '0)) || (w.avail && w.head_last);
         if (start) begin
            words_done <= '0;
         end else if (w.avail) begin
            ram_waddr  <= RAM_ADDR_W'(words_done * WORD_STRIDE);   // count doubles as index
            words_done <= words_done + LEN_W'(1);
         end
      end
   end

   always_ff @(posedge CLK) begin
      if (w.avail) begin
         ram_wdata <= w.head_word;
      end
   end

endmodule

`default_nettype wire

// File: tb_clock.sv
`timescale 1ns/100ps
`default_nettype none

module tb_clock #(
   parameter int HALF_PERIOD = 10   // ns, 20 ns period
) (
   output logic CLK
);

   initial begin
      CLK = 1'b0;
      forever #(HALF_PERIOD) CLK = ~CLK;
   end

endmodule

`default_nettype wire

// File: tb_efpga_xfer.sv
`timescale 1ns/100ps
`default_nettype none

module tb_efpga_xfer import efpga_xfer_pkg::*; ();

   localparam int NUM_TESTS = 5;
   localparam int LINT_WAIT = 20;   // cycles allowed for a lint grant or response

   logic                   CLK;
   logic                   rst_n;
   logic                   lint_req;
   logic                   lint_wen;
   logic [LINT_ADDR_W-1:0] lint_addr;
   logic [WORD_W-1:0]      lint_wdata;
   logic                   lint_gnt;
   logic                   lint_valid;
   logic [WORD_W-1:0]      lint_rdata;
   logic                   tcdm_req;
   logic [TCDM_ADDR_W-1:0] tcdm_addr;
   logic [BE_W-1:0]        tcdm_be;
   logic                   tcdm_gnt = 1'b0;
   logic                   tcdm_valid = 1'b0;
   logic [WORD_W-1:0]      tcdm_rdata = '0;
   logic                   ram_we;
   logic [RAM_ADDR_W-1:0]  ram_waddr;
   logic [WORD_W-1:0]      ram_wdata;
   logic [RAM_ADDR_W-1:0]  ram_raddr;
   logic [WORD_W-1:0]      ram_rdata = '0;

   // columns: start address, byte enables, word count, random stalls
   logic [TCDM_ADDR_W-1:0] row_addr  [NUM_TESTS] = '{20'h00100, 20'h02040, 20'h10008,
                                                    20'h0a000, 20'h00ffc};
   logic [BE_W-1:0]        row_be    [NUM_TESTS] = '{4'hf, 4'h3, 4'hc, 4'h5, 4'h9};
   logic [LEN_W-1:0]       row_len   [NUM_TESTS] = '{8'd8, 8'd12, 8'd0, 8'd20, 8'd1};
   logic                   row_stall [NUM_TESTS] = '{1'b0, 1'b1, 1'b1, 1'b1, 1'b0};

   int errors = 0;
   int tests_failed = 0;
   int grants = 0;
   int valids = 0;
   int req_cycles = 0;
   int cyc = 0;
   int gnt_wait = -1;   // idle when negative
   int last_due = 0;
   int lat;
   int due;
   int grants_at_start = 0;
   logic                   stall_on = 1'b0;
   logic [TCDM_ADDR_W-1:0] exp_addr = '0;
   logic [BE_W-1:0]        exp_be = '0;
   int                     resp_due [$];
   logic [WORD_W-1:0]      resp_data [$];
   logic [WORD_W-1:0]      ram_mem [1024];

   tb_clock clk_gen (.CLK(CLK));

   efpga_xfer_top dut (
      .CLK        (CLK),
      .rst_n      (rst_n),
      .lint_req   (lint_req),
      .lint_wen   (lint_wen),
      .lint_addr  (lint_addr),
      .lint_wdata (lint_wdata),
      .lint_gnt   (lint_gnt),
      .lint_valid (lint_valid),
      .lint_rdata (lint_rdata),
      .tcdm_req   (tcdm_req),
      .tcdm_addr  (tcdm_addr),
      .tcdm_be    (tcdm_be),
      .tcdm_gnt   (tcdm_gnt),
      .tcdm_valid (tcdm_valid),
      .tcdm_rdata (tcdm_rdata),
      .ram_we     (ram_we),
      .ram_waddr  (ram_waddr),
      .ram_wdata  (ram_wdata),
      .ram_raddr  (ram_raddr),
      .ram_rdata  (ram_rdata)
   );

   // TCDM contents: byte address times 3 plus 0x1000
   function automatic logic [WORD_W-1:0] tcdm_word(input logic [TCDM_ADDR_W-1:0] a);
      return {12'h000, a} * 32'd3 + 32'h1000;
   endfunction

   function automatic int total_length();
      int sum;
      sum = 0;
      for (int k = 0; k < NUM_TESTS; k++) begin
         sum += int'(row_len[k]);
      end
      return sum;
   endfunction

   task automatic check_value(input string name, input logic [WORD_W-1:0] got,
                              input logic [WORD_W-1:0] exp);
      assert (got === exp) else begin
         $display("FAILED at %0t: %s expected %h got %h", $time, name, exp, got);
         errors++;
      end
   endtask

   // call on a rising edge; returns once lint_valid is seen
   task automatic lint_access(input logic wen, input logic [LINT_ADDR_W-1:0] addr,
                              input logic [WORD_W-1:0] wdata, output logic [WORD_W-1:0] rdata);
      int waited;
      waited = 0;
      lint_req   <= 1'b1;
      lint_wen   <= wen;
      lint_addr  <= addr;
      lint_wdata <= wdata;
      do begin
         @(posedge CLK);
         waited++;
      end while (!lint_gnt && waited < LINT_WAIT);
      lint_req <= 1'b0;
      assert (lint_gnt) else begin
         $display("lint access to %h was never granted", addr);
         errors++;
      end
      waited = 0;
      do begin
         @(posedge CLK);
         waited++;
      end while (!lint_valid && waited < LINT_WAIT);
      assert (lint_valid) else begin
         $display("lint access to %h got no response", addr);
         errors++;
      end
      rdata = lint_rdata;
   endtask

   task automatic report_test(input string name, input int err_before);
      if (errors == err_before) begin
         $display("test %s: ok", name);
      end else begin
         $display("test %s: %0d errors", name, errors - err_before);
         tests_failed++;
      end
   endtask

   // TCDM slave with random grant and response delays
   always @(posedge CLK) begin
      if (tcdm_req) req_cycles++;
      if (tcdm_valid) valids++;
      tcdm_valid <= 1'b0;
      if (resp_data.size() > 0 && cyc >= resp_due[0]) begin
         tcdm_valid <= 1'b1;
         tcdm_rdata <= resp_data.pop_front();
         void'(resp_due.pop_front());
      end
      if (tcdm_req && tcdm_gnt) begin
         check_value("tcdm_addr", 32'(tcdm_addr),
                     32'(exp_addr + TCDM_ADDR_W'(WORD_STRIDE * (grants - grants_at_start))));
         check_value("tcdm_be", 32'(tcdm_be), 32'(exp_be));
         lat = stall_on ? 1 + int'($urandom % 4) : 1;
         due = cyc + lat;
         if (due <= last_due) due = last_due + 1;   // keep answers in order
         last_due = due;
         resp_due.push_back(due);
         resp_data.push_back(tcdm_word(tcdm_addr));
         grants++;
         gnt_wait = stall_on ? int'($urandom % 4) : 0;   // zero keeps gnt up back to back
         tcdm_gnt <= (gnt_wait == 0);
      end else if (tcdm_req) begin
         if (gnt_wait < 0) gnt_wait = stall_on ? int'($urandom % 4) : 0;
         if (gnt_wait == 0) tcdm_gnt <= 1'b1;
         else gnt_wait--;
      end
      assert (grants - valids <= FIFO_DEPTH) else begin
         $display("more than %0d TCDM reads outstanding at %0t", FIFO_DEPTH, $time);
         errors++;
      end
      cyc++;
   end

   // operand RAM, read data one cycle after the address
   initial begin
      for (int k = 0; k < 1024; k++) begin
         ram_mem[k] <= 32'h5a000000 ^ (32'(k) * 32'd4 * 32'd7);
      end
   end

   always @(posedge CLK) begin
      if (ram_we) ram_mem[ram_waddr[RAM_ADDR_W-1:2]] <= ram_wdata;
      ram_rdata <= ram_mem[ram_raddr[RAM_ADDR_W-1:2]];
   end

   initial begin : watchdog
      int limit;
      limit = total_length() * 20 + 2000;
      repeat (limit) @(posedge CLK);
      $display("watchdog expired after %0d cycles, run stopped", limit);
      $display("SOME TESTS FAILED");
      $finish;
   end

   initial begin : main
      int err_before;
      int polls;
      int req_before;
      logic [WORD_W-1:0] rd;
      logic [WORD_W-1:0] status;
      void'($urandom(73));
      rst_n      = 1'b0;
      lint_req   = 1'b0;
      lint_wen   = 1'b1;
      lint_addr  = '0;
      lint_wdata = '0;
      repeat (2) @(posedge CLK);
      rst_n <= 1'b1;
      @(posedge CLK);

      err_before = errors;
      check_value("lint_gnt", 32'(lint_gnt), 32'h0);
      check_value("lint_valid", 32'(lint_valid), 32'h0);
      check_value("tcdm_req", 32'(tcdm_req), 32'h0);
      check_value("ram_we", 32'(ram_we), 32'h0);
      lint_access(1'b1, REG_ID, '0, rd);
      check_value("lint_rdata (REG_ID)", rd, ID_WORD);
      lint_access(1'b1, REG_STATUS, '0, rd);
      check_value("lint_rdata (busy)", 32'(rd[0]), 32'h0);
      report_test("reset", err_before);

      for (int t = 0; t < NUM_TESTS; t++) begin
         err_before = errors;
         stall_on   = row_stall[t];
         lint_access(1'b0, REG_CFG, {8'hff, ~row_be[t], row_addr[t]}, rd);
         lint_access(1'b0, REG_LEN, 32'(row_len[t]), rd);
         lint_access(1'b1, REG_CFG, '0, rd);
         check_value("lint_rdata (REG_CFG)", rd, {8'h00, ~row_be[t], row_addr[t]});
         lint_access(1'b1, REG_LEN, '0, rd);
         check_value("lint_rdata (REG_LEN)", rd, 32'(row_len[t]));

         exp_addr        = row_addr[t];
         exp_be          = row_be[t];
         grants_at_start = grants;
         req_before      = req_cycles;
         lint_access(1'b0, REG_START, '0, rd);

         status = '0;
         polls  = 0;
         while (!status[1] && polls < 50 + 20 * int'(row_len[t])) begin
            lint_access(1'b1, REG_STATUS, '0, status);
            polls++;
         end
         assert (status[1]) else begin
            $display("test %0d: transfer never reported done", t);
            errors++;
         end
         check_value("lint_rdata (REG_STATUS)", status, {16'h0000, row_len[t], 8'h02});

         for (int i = 0; i < int'(row_len[t]); i++) begin
            check_value($sformatf("ram word @%0h", 4 * i), ram_mem[i],
                        tcdm_word(row_addr[t] + TCDM_ADDR_W'(WORD_STRIDE * i)));
            lint_access(1'b1, {RAM_WINDOW, 12'(WORD_STRIDE * i)}, '0, rd);
            check_value($sformatf("lint_rdata (window @%0h)", 4 * i), rd,
                        tcdm_word(row_addr[t] + TCDM_ADDR_W'(WORD_STRIDE * i)));
         end
         if (row_len[t] == '0) begin
            check_value("tcdm_req cycles", 32'(req_cycles - req_before), 32'h0);
         end
         report_test($sformatf("%0d (addr %h len %0d stalls %0d)", t, row_addr[t],
                               row_len[t], row_stall[t]), err_before);
      end

      $display("%0d tests run, %0d failed, %0d check errors", NUM_TESTS + 1,
               tests_failed, errors);
      if (errors == 0) begin
         $display("ALL TESTS PASSED");
      end else begin
         $display("SOME TESTS FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: tcdm_reader.sv
`timescale 1ns/100ps
`default_nettype none

module tcdm_reader import efpga_xfer_pkg::*; (
   input  wire                    CLK,
   input  wire                    rst_n,
   input  wire                    start,
   input  wire [TCDM_ADDR_W-1:0]  start_addr,
   input  wire [BE_W-1:0]         start_be,
   input  wire [LEN_W-1:0]        length,
   output logic                   tcdm_req,
   output logic [TCDM_ADDR_W-1:0] tcdm_addr,
   output logic [BE_W-1:0]        tcdm_be,
   input  wire                    tcdm_gnt,
   input  wire                    tcdm_valid,
   input  wire [WORD_W-1:0]       tcdm_rdata,
   xfer_if.reader                 x
);

   logic                active;
   logic [LEN_W-1:0]    issued;
   logic [LEN_W-1:0]    issued_nxt;
   logic [LEN_W-1:0]    recv;
   logic [CREDIT_W-1:0] credits;
   logic [CREDIT_W-1:0] credits_nxt;
   logic                granted;

   assign granted     = tcdm_req & tcdm_gnt;
   assign issued_nxt  = issued + LEN_W'(granted);
   assign credits_nxt = credits - CREDIT_W'(granted) + CREDIT_W'(x.credit);

   always_ff @(posedge CLK or negedge rst_n) begin
      if (!rst_n) begin
         active    <= 1'b0;
         issued    <= '0;
         credits   <= CREDIT_W'(FIFO_DEPTH);
         tcdm_req  <= 1'b0;
         tcdm_addr <= '0;
         tcdm_be   <= '0;
      end else if (start) begin
         active    <= (length != '0);
         issued    <= '0;
         credits   <= CREDIT_W'(FIFO_DEPTH);
         tcdm_req  <= 1'b0;
         tcdm_addr <= start_addr;
         tcdm_be   <= start_be;
      end else begin
         credits <= credits_nxt;
         issued  <= issued_nxt;
         if (granted) begin
            tcdm_addr <= tcdm_addr + TCDM_ADDR_W'(WORD_STRIDE);
         end
         if (issued_nxt == length) begin
            active <= 1'b0;
         end
         // an ungranted request keeps its credit, so req stays up
         tcdm_req <= active && (issued_nxt != length) && (credits_nxt != '0);
      end
   end

   always_ff @(posedge CLK or negedge rst_n) begin
      if (!rst_n) begin
         recv        <= '0;
         x.push      <= 1'b0;
         x.push_last <= 1'b0;
      end else begin
         x.push      <= tcdm_valid;
         x.push_last <= tcdm_valid && (recv == length - LEN_W'(1));
         if (start) begin
            recv <= '0;
         end else if (tcdm_valid) begin
            recv <= recv + LEN_W'(1);
         end
      end
   end

   always_ff @(posedge CLK) begin
      if (tcdm_valid) begin
         x.push_word <= tcdm_rdata;
      end
   end

   // words granted but not yet popped never exceed the buffer
   a_credit_max: assert property (@(posedge CLK) disable iff (!rst_n)
      credits <= CREDIT_W'(FIFO_DEPTH))
      else $error("credit count above FIFO depth");

endmodule

`default_nettype wire

// File: word_fifo.sv
`timescale 1ns/100ps
`default_nettype none

module word_fifo import efpga_xfer_pkg::*; (
   input wire     CLK,
   input wire     rst_n,
   xfer_if.buffer b
);

   logic [WORD_W-1:0]             mem_word [FIFO_DEPTH];
   logic                          mem_last [FIFO_DEPTH];
   logic [$clog2(FIFO_DEPTH)-1:0] wr_ptr;
   logic [$clog2(FIFO_DEPTH)-1:0] rd_ptr;
   logic [CREDIT_W-1:0]           count;
   logic                          empty;
   logic                          full;
   logic                          do_push;
   logic                          do_pop;

   assign empty   = (count == '0);
   assign full    = (count == CREDIT_W'(FIFO_DEPTH));
   assign do_push = b.push & ~full;
   assign do_pop  = b.pop & ~empty;

   assign b.avail     = ~empty;
   assign b.head_word = mem_word[rd_ptr];
   assign b.head_last = mem_last[rd_ptr];
   assign b.credit    = do_pop;   // slot freed this edge

   always_ff @(posedge CLK) begin
      if (do_push) begin
         mem_word[wr_ptr] <= b.push_word;
         mem_last[wr_ptr] <= b.push_last;
      end
   end

   always_ff @(posedge CLK or negedge rst_n) begin
      if (!rst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_push) begin
            wr_ptr <= (wr_ptr == FIFO_DEPTH - 1) ? '0 : wr_ptr + 1'b1;
         end
         if (do_pop) begin
            rd_ptr <= (rd_ptr == FIFO_DEPTH - 1) ? '0 : rd_ptr + 1'b1;
         end
         count <= count + CREDIT_W'(do_push) - CREDIT_W'(do_pop);
      end
   end

   // credits upstream and avail downstream keep both sides in bounds
   a_no_overflow: assert property (@(posedge CLK) disable iff (!rst_n)
      !(b.push && full) && !(b.pop && empty))
      else $error("word FIFO push while full or pop while empty");

endmodule

`default_nettype wire

// File: xfer_if.sv
`timescale 1ns/100ps
`default_nettype none

interface xfer_if import efpga_xfer_pkg::*; ();

   logic              push;
   logic [WORD_W-1:0] push_word;
   logic              push_last;
   logic              credit;      // one pulse per word popped
   logic              avail;
   logic [WORD_W-1:0] head_word;
   logic              head_last;
   logic              pop;

   modport reader (output push, push_word, push_last, input credit);

   modport buffer (input push, push_word, push_last, pop,
                   output credit, avail, head_word, head_last);

   modport writer (input avail, head_word, head_last, output pop);

endinterface

`default_nettype wire
